// File: build_sim.sh
#!/bin/sh
# build and run the cell_trng testbench with Verilator
# exit status 0 only when the log shows a passing run

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_trng --Mdir "$OBJ" -o tb_trng -f cell_trng.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/tb_trng" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict on a line of its own
if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
exit 1

// File: cell_trng.f
verilog/trng_pkg.sv
verilog/trng_cell.sv
verilog/trng_entropy_src.sv
verilog/trng_debias.sv
verilog/trng_sampler.sv
verilog/trng_post_proc.sv
verilog/trng_top.sv
test/trng_properties.sv
test/tb_trng.sv

// File: test/tb_trng.sv
/*
 * cell_trng testbench
 * drives enable bursts of random length into trng_top, records
 * every valid_o pulse and checks spacing, disable latency,
 * bit balance and value repetition
 */
module tb_trng;
    import trng_pkg::*;

    localparam bit POST_PROC_EN = 1'b1;
    localparam int NUM_BYTES    = 64;             // bytes for the statistics
    localparam int PULSE_WAIT   = 4000;           // cycles allowed per first pulse
    localparam int QUIET_CYC    = 300;            // minimum disabled stretch
    localparam int MAX_BURSTS   = 80;
    localparam int NO_LIMIT     = 32'h7fff_ffff;

    logic        clk_i;
    logic        rstn_i;
    logic        enable_i;
    rnd_byte_t   data_o;
    logic        valid_o;

    logic [15:0] lfsr_q;        // stimulus LFSR
    rnd_byte_t   byte_q[$];     // every pulsed byte, in order
    int          cyc;           // negedge count after reset
    int          last_pulse;    // cycle of the previous pulse
    int          idle_cyc;      // cycles with enable low
    int          value_errs;
    int          timeout_errs;

    trng_top #(
        .POST_PROC_EN (POST_PROC_EN),
        .SIM_MODE     (1'b1)
    ) DUT (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .enable_i (enable_i),
        .data_o   (data_o),
        .valid_o  (valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // reference and helpers
    // ----------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16,14,13,11
    endfunction

    // one LFSR step per bit taken
    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    // each de-biased bit needs a pair of cycles
    function automatic int expected_min_gap();
        if (POST_PROC_EN) begin
            return 2 * SAMPLE_BITS * POST_SAMPLES;
        end else begin
            return 2 * SAMPLE_BITS;
        end
    endfunction

    function automatic int popcount(input rnd_byte_t b);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            n += int'(b[i]);
        end
        return n;
    endfunction

    task automatic check_byte(input string name, input rnd_byte_t exp, input rnd_byte_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected 0x%02h actual 0x%02h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    // range compare, lo..hi inclusive
    task automatic check_count(input string name, input int lo, input int hi, input int act);
        if (act < lo || act > hi) begin
            $display("FAIL %0t %s expected %0d..%0d actual %0d", $time, name, lo, hi, act);
            value_errs++;
        end
    endtask

    task automatic set_enable(input logic v);
        @(posedge clk_i);
        #1;
        enable_i = v;   // just after the edge
    endtask

    task automatic wait_pulse(input int limit);
        int start;
        int n;
        start = byte_q.size();
        n     = 0;
        while (byte_q.size() == start && n < limit) begin
            @(posedge clk_i);
            n++;
        end
        if (byte_q.size() == start) begin
            $display("timeout: no valid_o pulse within %0d cycles of enable", limit);
            timeout_errs++;
        end
    endtask

    // ----------------------------------------------------------
    // pulse monitor, samples away from the rising edge
    // ----------------------------------------------------------
    always @(negedge clk_i) begin
        if (rstn_i) begin
            cyc++;
            idle_cyc = enable_i ? 0 : idle_cyc + 1;
            if (valid_o) begin
                if (last_pulse >= 0) begin
                    check_count("valid_o gap", expected_min_gap(), NO_LIMIT, cyc - last_pulse);
                end
                if (!enable_i) begin
                    check_count("valid_o cycles after disable", 0, 3, idle_cyc);
                end
                last_pulse = cyc;
                byte_q.push_back(data_o);
            end
        end
    end

    // ----------------------------------------------------------
    // stimulus and final report
    // ----------------------------------------------------------
    initial begin
        int ext;
        int off;
        int burst;
        int n;
        int ones;
        int run;
        int max_run;
        lfsr_q       = 16'd7;
        cyc          = 0;
        last_pulse   = -1;
        idle_cyc     = 0;
        value_errs   = 0;
        timeout_errs = 0;
        rstn_i       = 1'b0;
        enable_i     = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // idle after reset
        repeat (50) @(posedge clk_i);
        #1;
        check_byte("data_o", 8'h00, data_o);
        check_count("valid_o pulses while disabled", 0, 0, byte_q.size());

        // bursts of random length, each followed by a quiet stretch
        burst = 0;
        while (byte_q.size() < NUM_BYTES && burst < MAX_BURSTS) begin
            set_enable(1'b1);
            wait_pulse(PULSE_WAIT);
            rand_bits(9, ext);
            repeat (ext + 16) @(posedge clk_i);
            set_enable(1'b0);
            rand_bits(7, off);
            repeat (QUIET_CYC + off) @(posedge clk_i);   // monitor flags late pulses
            burst++;
        end
        if (byte_q.size() < NUM_BYTES) begin
            $display("error: only %0d of %0d bytes collected", byte_q.size(), NUM_BYTES);
            timeout_errs++;
        end

        // statistics over the first bytes
        n       = (byte_q.size() < NUM_BYTES) ? byte_q.size() : NUM_BYTES;
        ones    = 0;
        run     = 0;
        max_run = 0;
        for (int i = 0; i < n; i++) begin
            ones += popcount(byte_q[i]);
            if (i > 0 && byte_q[i] == byte_q[i-1]) begin
                run++;
            end else begin
                run = 1;
            end
            if (run > max_run) begin
                max_run = run;
            end
        end
        check_count("popcount", (n * 8 * 40 + 99) / 100, (n * 8 * 60) / 100, ones);
        check_count("repeated byte run", 0, 4, max_run);

        $display("errors: value %0d, timeout %0d, bytes %0d",
                 value_errs, timeout_errs, byte_q.size());
        if (value_errs + timeout_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: test/trng_properties.sv
/*
 * cell_trng strobe properties
 * concurrent checks on the top level outputs, bound into trng_top
 */
module trng_properties (
    input logic                clk_i,
    input logic                rstn_i,
    input logic                valid_o,
    input trng_pkg::rnd_byte_t data_o
);

    // ----------------------------------------------------------
    // strobe shape
    // ----------------------------------------------------------
    a_single_pulse : assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o |=> !valid_o)
        else $error("valid_o high for two cycles in a row");

    // no strobe while reset is held
    a_reset_quiet : assert property (@(posedge clk_i)
        !rstn_i |-> !valid_o)
        else $error("valid_o high during reset");

    // byte only moves together with its strobe
    a_data_hold : assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$stable(data_o) |-> valid_o)
        else $error("data_o changed without valid_o");

endmodule

bind trng_top trng_properties u_props (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .valid_o (valid_o),
    .data_o  (data_o)
);

// File: verilog/trng_cell.sv
/*
 * trng entropy cell
 * ring oscillator with a short and a long inverter path,
 * path chosen by select_i, latches switched on one by one.
 * SIM_MODE swaps the ring for an LFSR toggle model
 */
module trng_cell #(
    parameter int          NUM_INV_S = 3,          // short path length, odd
    parameter int          NUM_INV_L = 5,          // long path length, odd
    parameter bit          SIM_MODE  = 1'b0,       // 1: LFSR model instead of ring
    parameter logic [15:0] CELL_SEED = 16'h0001    // model seed, differs per cell
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic select_i,   // 0 short path, 1 long path
    input  logic enable_i,
    output logic enable_o,   // enable_i one clock later
    output logic data_o      // sampled ring output
);

    logic en_q;   // enable shift stage

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            en_q <= 1'b0;
        end else begin
            en_q <= enable_i;
        end
    end

    assign enable_o = en_q;   // next cell in the chain

    // ----------------------------------------------------------
    // hardware ring
    // ----------------------------------------------------------
    if (SIM_MODE == 1'b0) begin : g_ring
        logic [NUM_INV_L-1:0] en_sreg;   // per-latch enables
        logic [NUM_INV_L-1:0] inv;       // latch outputs
        logic [NUM_INV_L-1:0] prev;      // input of each stage
        logic                 fb;        // ring feedback
        logic                 smp_q;

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                en_sreg <= '0;
                smp_q   <= 1'b0;
            end else begin
                en_sreg <= {en_sreg[NUM_INV_L-2:0], en_q};   // stages wake up in order
                smp_q   <= fb;                                // capture ring state
            end
        end

        // tap after the short path or at the end of the chain
        assign fb   = select_i ? inv[NUM_INV_L-1] : inv[NUM_INV_S-1];
        assign prev = {inv[NUM_INV_L-2:0], fb};

        for (genvar k = 0; k < NUM_INV_L; k++) begin : g_stage
            // transparent while enabled, holds otherwise
            always_latch begin
                if (!rstn_i) begin
                    inv[k] <= 1'b0;
                end else if (en_sreg[k]) begin
                    inv[k] <= ~prev[k];   // one inverter per stage
                end
            end
        end

        assign data_o = smp_q;

    // ----------------------------------------------------------
    // simulation model
    // ----------------------------------------------------------
    end else begin : g_model
        localparam int CNT_W = $clog2(NUM_INV_L + 1);

        logic [15:0]      lfsr;
        logic [CNT_W-1:0] cnt_q;    // cycles to next toggle
        logic [CNT_W-1:0] bound;    // path length stands in for delay
        logic [CNT_W-1:0] reload;
        logic             tgl_q;

        assign bound  = select_i ? CNT_W'(NUM_INV_L) : CNT_W'(NUM_INV_S);
        assign reload = CNT_W'(lfsr % 16'(bound));   // 0 .. bound-1

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                lfsr  <= CELL_SEED | 16'h0001;   // never all zero
                cnt_q <= '0;
                tgl_q <= 1'b0;
            end else if (en_q) begin
                // taps 16,14,13,11
                lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
                if (cnt_q == '0) begin
                    tgl_q <= ~tgl_q;
                    cnt_q <= reload;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end else begin
                cnt_q <= '0;     // stopped ring
                tgl_q <= 1'b0;
            end
        end

        assign data_o = tgl_q;
    end

endmodule

// File: verilog/trng_debias.sv
/*
 * trng de-biasing
 * two-flop synchronizer for the raw cell output and a von
 * Neumann extractor judging non-overlapping bit pairs
 */
module trng_debias (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               rnd_raw_i,     // async ring output
    input  logic               src_ready_i,   // last cell enabled
    output logic               sel_dir_o,     // feedback direction
    output trng_pkg::db_bit_t  bit_o
);

    logic [1:0] sync_q;   // [0] first stage, [1] safe
    logic [1:0] hist_q;   // [1] older, [0] newer
    logic       state_q;  // high on every second cycle

    // ----------------------------------------------------------
    // synchronizer and pair history
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sync_q  <= '0;
            hist_q  <= '0;
            state_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], rnd_raw_i};
            hist_q  <= {hist_q[0], sync_q[1]};
            // alternate only while the source runs
            state_q <= ~state_q & src_ready_i;
        end
    end

    // first stage steers the chain, metastable or not
    assign sel_dir_o = sync_q[0];

    // ----------------------------------------------------------
    // von Neumann rule
    // ----------------------------------------------------------
    // 01 and 10 give a bit, 00 and 11 are dropped
    assign bit_o.valid = state_q & (hist_q[1] ^ hist_q[0]);
    assign bit_o.data  = hist_q[0];   // newer bit of the pair

endmodule

// File: verilog/trng_entropy_src.sv
/*
 * trng entropy source
 * array of entropy cells with a shifted enable chain and a
 * feedback chain whose direction follows the synchronized bit
 */
module trng_entropy_src #(
    parameter int NUM_CELLS     = 3,      // at least 2
    parameter int NUM_INV_START = 3,      // first cell short path, odd
    parameter int NUM_INV_INC   = 2,      // increment per cell, even
    parameter int NUM_INV_DELAY = 2,      // long path extra, even
    parameter bit SIM_MODE      = 1'b0
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic enable_i,      // sample enable level
    input  logic sel_dir_i,     // 0 forward, 1 backward
    output logic rnd_raw_o,     // last cell, asynchronous to consumers
    output logic src_ready_o    // last cell enabled
);

    logic [NUM_CELLS-1:0] en_in;      // cell enables
    logic [NUM_CELLS-1:0] en_out;     // delayed enables
    logic [NUM_CELLS-1:0] cell_out;   // cell data
    logic [NUM_CELLS-1:0] cell_sel;   // path select per cell

    // ----------------------------------------------------------
    // cell array
    // ----------------------------------------------------------
    for (genvar i = 0; i < NUM_CELLS; i++) begin : g_cell
        trng_cell #(
            .NUM_INV_S (NUM_INV_START + i * NUM_INV_INC),
            .NUM_INV_L (NUM_INV_START + i * NUM_INV_INC + NUM_INV_DELAY),
            .SIM_MODE  (SIM_MODE),
            .CELL_SEED (16'(16'hACE1 + i * 16'h3B57))   // distinct per cell
        ) u_cell (
            .clk_i    (clk_i),
            .rstn_i   (rstn_i),
            .select_i (cell_sel[i]),
            .enable_i (en_in[i]),
            .enable_o (en_out[i]),
            .data_o   (cell_out[i])
        );
    end

    // enable ripples one cell per clock
    assign en_in = {en_out[NUM_CELLS-2:0], enable_i};

    // ----------------------------------------------------------
    // feedback chain
    // ----------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_CELLS; i++) begin
            if (sel_dir_i) begin
                cell_sel[i] = cell_out[(i + 1) % NUM_CELLS];               // upper neighbour
            end else begin
                cell_sel[i] = cell_out[(i + NUM_CELLS - 1) % NUM_CELLS];   // lower neighbour
            end
        end
    end

    assign rnd_raw_o   = cell_out[NUM_CELLS-1];
    assign src_ready_o = en_out[NUM_CELLS-1];   // chain fully running

endmodule

// File: verilog/trng_pkg.sv
/*
 * cell_trng shared definitions
 * random byte type, de-biased bit and raw sample structs,
 * post-processor states and the sampling geometry
 */
package trng_pkg;

    // ----------------------------------------------------------
    // data types
    // ----------------------------------------------------------
    typedef logic [7:0] rnd_byte_t;   // one random data byte

    // output of the von Neumann extractor
    typedef struct packed {
        logic valid;   // set for patterns 01 and 10 only
        logic data;    // newer bit of the pair
    } db_bit_t;

    // raw byte from the sampler
    typedef struct packed {
        logic      valid;   // single-cycle strobe
        rnd_byte_t data;    // eight de-biased bits
    } sample_t;

    // ----------------------------------------------------------
    // post-processor FSM
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        POST_IDLE    = 2'b00,   // sampler not running
        POST_START   = 2'b01,   // clear buffer and counter
        POST_COMBINE = 2'b10    // fold raw bytes into buffer
    } post_state_e;

    // geometry
    localparam int SAMPLE_BITS  = 8;   // de-biased bits per raw byte
    localparam int POST_SAMPLES = 8;   // raw bytes per whitened byte

endpackage

// File: verilog/trng_post_proc.sv
/*
 * trng post-processor
 * folds eight raw bytes into one whitened byte by rotating the
 * buffer right and adding each new sample
 */
module trng_post_proc (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                run_i,      // sampler running
    input  trng_pkg::sample_t   sample_i,
    output trng_pkg::rnd_byte_t data_o,
    output logic                valid_o
);
    import trng_pkg::*;

    localparam int               CNT_W    = $clog2(POST_SAMPLES + 1);
    localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(POST_SAMPLES);

    post_state_e      state_q;
    logic [CNT_W-1:0] cnt_q;     // samples folded so far
    rnd_byte_t        acc_q;     // combine buffer
    rnd_byte_t        data_q;    // output byte, changes with valid
    logic             valid_q;

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= POST_IDLE;
            cnt_q   <= '0;
            acc_q   <= '0;
            data_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;   // strobe by default low
            if (!run_i) begin
                state_q <= POST_IDLE;   // sampler stopped
            end else begin
                case (state_q)
                    POST_IDLE: begin
                        state_q <= POST_START;   // run just rose
                    end
                    POST_START: begin
                        cnt_q   <= '0;
                        acc_q   <= '0;
                        state_q <= POST_COMBINE;
                    end
                    POST_COMBINE: begin
                        if (cnt_q == CNT_DONE) begin
                            data_q  <= acc_q;    // publish result
                            valid_q <= 1'b1;
                            state_q <= POST_START;
                        end else if (sample_i.valid) begin
                            // rotate right, then add
                            acc_q <= {acc_q[0], acc_q[7:1]} + sample_i.data;
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    default: begin
                        state_q <= POST_IDLE;
                    end
                endcase
            end
        end
    end

    assign data_o  = data_q;
    assign valid_o = valid_q;

endmodule

// File: verilog/trng_sampler.sv
/*
 * trng sampler
 * packs de-biased bits into raw bytes and strobes each byte
 * one cycle after its last bit
 */
module trng_sampler (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              enable_i,   // sample enable level
    input  trng_pkg::db_bit_t bit_i,
    output logic              run_o,      // sampling has started
    output trng_pkg::sample_t sample_o
);
    import trng_pkg::*;

    localparam int               CNT_W    = $clog2(SAMPLE_BITS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SAMPLE_BITS - 1);

    logic [CNT_W-1:0] cnt_q;    // bits in current group
    logic             run_q;
    rnd_byte_t        sreg_q;   // bit shift register
    sample_t          smp_q;    // held byte and strobe
    logic             wrap;     // last bit of a group

    assign wrap = enable_i & run_q & bit_i.valid & (cnt_q == CNT_LAST);

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
            run_q <= 1'b0;
            smp_q <= '0;
        end else begin
            if (!enable_i) begin
                cnt_q <= '0;      // restart grouping
                run_q <= 1'b0;
            end else if (bit_i.valid) begin
                cnt_q <= wrap ? '0 : cnt_q + 1'b1;
                run_q <= 1'b1;    // first bit starts the run
            end
            smp_q.valid <= wrap;
            if (wrap) begin
                smp_q.data <= {sreg_q[6:0], bit_i.data};   // byte held until next wrap
            end
        end
    end

    // shift in every extracted bit
    always_ff @(posedge clk_i) begin
        if (bit_i.valid) begin
            sreg_q <= {sreg_q[6:0], bit_i.data};
        end
    end

    assign run_o    = run_q;
    assign sample_o = smp_q;

endmodule

// File: verilog/trng_top.sv
/*
 * cell_trng top level
 * registers the enable, builds the entropy source, de-biasing
 * and sampler, and optionally the post-processor
 */
module trng_top #(
    parameter int NUM_CELLS     = 3,      // ring cells, at least 2
    parameter int NUM_INV_START = 3,      // first short path, odd
    parameter int NUM_INV_INC   = 2,      // per-cell increment, even
    parameter int NUM_INV_DELAY = 2,      // long path extra, even
    parameter bit POST_PROC_EN  = 1'b1,   // build the whitening stage
    parameter bit SIM_MODE      = 1'b1    // LFSR cell model
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                enable_i,
    output trng_pkg::rnd_byte_t data_o,
    output logic                valid_o
);
    import trng_pkg::*;

    logic    en_q;        // sample enable level
    logic    rnd_raw;     // last cell output
    logic    src_ready;
    logic    sel_dir;     // feedback direction
    logic    run;
    db_bit_t db_bit;
    sample_t sample;

    // ----------------------------------------------------------
    // static parameter checks
    // ----------------------------------------------------------
    if (NUM_CELLS < 2) begin : g_chk_cells
        $error("trng_top: NUM_CELLS must be at least 2");
    end
    if ((NUM_INV_START % 2) == 0) begin : g_chk_start
        $error("trng_top: NUM_INV_START must be odd");
    end
    if ((NUM_INV_INC % 2) != 0) begin : g_chk_inc
        $error("trng_top: NUM_INV_INC must be even");
    end
    if ((NUM_INV_DELAY % 2) != 0) begin : g_chk_delay
        $error("trng_top: NUM_INV_DELAY must be even");
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            en_q <= 1'b0;
        end else begin
            en_q <= enable_i;
        end
    end

    // ----------------------------------------------------------
    // processing chain
    // ----------------------------------------------------------
    trng_entropy_src #(
        .NUM_CELLS     (NUM_CELLS),
        .NUM_INV_START (NUM_INV_START),
        .NUM_INV_INC   (NUM_INV_INC),
        .NUM_INV_DELAY (NUM_INV_DELAY),
        .SIM_MODE      (SIM_MODE)
    ) u_src (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .enable_i    (en_q),
        .sel_dir_i   (sel_dir),
        .rnd_raw_o   (rnd_raw),
        .src_ready_o (src_ready)
    );

    trng_debias u_debias (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .rnd_raw_i   (rnd_raw),
        .src_ready_i (src_ready),
        .sel_dir_o   (sel_dir),
        .bit_o       (db_bit)
    );

    trng_sampler u_sampler (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .enable_i (en_q),
        .bit_i    (db_bit),
        .run_o    (run),
        .sample_o (sample)
    );

    if (POST_PROC_EN) begin : g_post
        trng_post_proc u_post (
            .clk_i    (clk_i),
            .rstn_i   (rstn_i),
            .run_i    (run),
            .sample_i (sample),
            .data_o   (data_o),
            .valid_o  (valid_o)
        );
    end else begin : g_raw
        assign data_o  = sample.data;    // raw bytes straight out
        assign valid_o = sample.valid;
    end

endmodule
